// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_mem_unit
BUILD_DIR ?= obj_dir
FILELIST ?= files.f
VFLAGS ?= --binary --timing --assert -Wno-fatal
RUN_ARGS ?=

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: files.f
+incdir+.
gpu_mem_pkg.sv
mem_issue.sv
mem_lane_agu.sv
mem_access.sv
mem_writeback.sv
mem_unit.sv
mem_unit_assert.sv
tb_mem_unit.sv

// File: gpu_mem_defs.svh
`ifndef GPU_MEM_DEFS_SVH
`define GPU_MEM_DEFS_SVH

//////////////////////////////////////////////////
// Lane geometry
//////////////////////////////////////////////////
`define NUM_LANES 8
`define LANE_W 32
`define OFF_W 16

//////////////////////////////////////////////////
// Instruction tags
//////////////////////////////////////////////////
`define WARP_W 3
`define SCB_W 2
`define REG_W 5

//////////////////////////////////////////////////
// Memories and latency
//////////////////////////////////////////////////
`define GM_WORDS 256
`define SM_WORDS 256
`define WADDR_W 8
`define LAT_W 5
`define LAT_RESET 4

`endif

// File: gpu_mem_pkg.sv
`include "gpu_mem_defs.svh"

package gpu_mem_pkg;

	typedef enum logic [1:0] {OP_NONE = 2'd0, OP_LOAD = 2'd1, OP_STORE = 2'd2} mem_op_e;

	typedef enum logic {SPACE_GLOBAL = 1'b0, SPACE_SHARED = 1'b1} mem_space_e;

	typedef enum logic {ACC_IDLE = 1'b0, ACC_WAIT = 1'b1} acc_state_e;

	//////////////////////////////////////////////////
	// Stage payloads
	//////////////////////////////////////////////////
	typedef struct packed
	{
		mem_op_e op;
		mem_space_e space;
		logic [`WARP_W-1:0] warp_id;
		logic [`SCB_W-1:0] scb_id;
		logic [`REG_W-1:0] reg_addr;
		logic [`OFF_W-1:0] offset;
		logic [`NUM_LANES-1:0] pam;	// Raw predicate mask, reported on a replay.
	} instr_hdr_t;

	typedef struct packed
	{
		logic active;
		logic [`LANE_W-1:0] rs;
		logic [`LANE_W-1:0] rt;
	} lane_req_t;

	typedef struct packed
	{
		logic active;
		logic [`WADDR_W-1:0] addr;
		logic [`LANE_W-1:0] wdata;
	} agu_out_t;

	typedef struct packed
	{
		mem_op_e op;
		logic [`WARP_W-1:0] warp_id;
		logic [`SCB_W-1:0] scb_id;
		logic [`REG_W-1:0] reg_addr;
		logic [`NUM_LANES-1:0] mask;
		logic [`NUM_LANES*`LANE_W-1:0] rdata;
	} wb_pkt_t;

	typedef struct packed
	{
		logic valid;
		logic [`WARP_W-1:0] warp_id;
		logic [`SCB_W-1:0] scb_id;
		logic [`NUM_LANES-1:0] mask;
	} fb_t;

endpackage

// File: mem_access.sv
`timescale 1ns/10ps
`include "gpu_mem_defs.svh"

module mem_access import gpu_mem_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  instr_hdr_t hdr_i,
	input  logic hdr_valid_i,
	input  agu_out_t [`NUM_LANES-1:0] lanes_i,
	input  logic fio_lat_we_i,
	input  logic [`LAT_W-1:0] fio_lat_i,
	output logic [`LAT_W-1:0] fio_lat_o,
	input  logic fio_mem_we_i,
	input  mem_space_e fio_space_i,
	input  logic [`WADDR_W-1:0] fio_addr_i,
	input  logic [`LANE_W-1:0] fio_wdata_i,
	output logic [`LANE_W-1:0] fio_rdata_o,
	output wb_pkt_t wb_o,
	output logic wb_valid_o,
	output fb_t neg_fb_o
);

	logic [`LANE_W-1:0] gm_mem [`GM_WORDS];
	logic [`LANE_W-1:0] sm_mem [`SM_WORDS];

	acc_state_e state_q;
	logic [`LAT_W-1:0] lat_q;
	logic [`LAT_W-1:0] cnt_q;

	logic arrive;
	logic accept;
	logic drop;
	logic is_shared;
	logic [`NUM_LANES-1:0] mask;
	logic [`NUM_LANES*`LANE_W-1:0] rdata;

	logic neg_valid_q;
	logic [`WARP_W-1:0] neg_warp_q;
	logic [`SCB_W-1:0] neg_scb_q;
	logic [`NUM_LANES-1:0] neg_mask_q;

	assign arrive = hdr_valid_i && (hdr_i.op != OP_NONE);
	assign accept = arrive && (state_q == ACC_IDLE);
	assign drop = arrive && (state_q == ACC_WAIT);	// Scoreboard replays these.
	assign is_shared = (hdr_i.space == SPACE_SHARED);

	//////////////////////////////////////////////////
	// Lane reads
	//////////////////////////////////////////////////
	always_comb
	begin
		for (int k = 0; k < `NUM_LANES; k++)
		begin
			mask[k] = lanes_i[k].active;
			if (!lanes_i[k].active)
				rdata[k*`LANE_W +: `LANE_W] = '0;
			else if (is_shared)
				rdata[k*`LANE_W +: `LANE_W] = sm_mem[lanes_i[k].addr];
			else
				rdata[k*`LANE_W +: `LANE_W] = gm_mem[lanes_i[k].addr];
		end
	end

	assign fio_rdata_o = (fio_space_i == SPACE_SHARED) ? sm_mem[fio_addr_i] : gm_mem[fio_addr_i];
	assign fio_lat_o = lat_q;

	//////////////////////////////////////////////////
	// Word arrays
	//////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (fio_mem_we_i)
		begin
			if (fio_space_i == SPACE_SHARED)
				sm_mem[fio_addr_i] <= fio_wdata_i;
			else
				gm_mem[fio_addr_i] <= fio_wdata_i;
		end
		if (accept && (hdr_i.op == OP_STORE))
		begin
			for (int k = 0; k < `NUM_LANES; k++)
			begin
				if (lanes_i[k].active && is_shared)
					sm_mem[lanes_i[k].addr] <= lanes_i[k].wdata;
				else if (lanes_i[k].active)
					gm_mem[lanes_i[k].addr] <= lanes_i[k].wdata;
			end
		end
	end

	// The result register also holds a pending global access.
	always_ff @(posedge clk)
	begin
		if (accept)
			wb_o <= '{op: hdr_i.op, warp_id: hdr_i.warp_id, scb_id: hdr_i.scb_id,
				reg_addr: hdr_i.reg_addr, mask: mask, rdata: rdata};
		if (drop)
		begin
			neg_warp_q <= hdr_i.warp_id;
			neg_scb_q <= hdr_i.scb_id;
			neg_mask_q <= hdr_i.pam;
		end
	end

	//////////////////////////////////////////////////
	// Access FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			state_q <= ACC_IDLE;
			cnt_q <= '0;
			lat_q <= `LAT_W'(`LAT_RESET);
			wb_valid_o <= 1'b0;
			neg_valid_q <= 1'b0;
		end
		else
		begin
			wb_valid_o <= 1'b0;
			neg_valid_q <= drop;
			if (fio_lat_we_i)
				lat_q <= fio_lat_i;
			case (state_q)
				ACC_IDLE:
				begin
					if (accept && (is_shared || (lat_q == '0)))
						wb_valid_o <= 1'b1;
					else if (accept)
					begin
						state_q <= ACC_WAIT;
						cnt_q <= lat_q;	// Stand-in for the miss penalty.
					end
				end
				ACC_WAIT:
				begin
					if (cnt_q == `LAT_W'd1)
					begin
						state_q <= ACC_IDLE;
						wb_valid_o <= 1'b1;
					end
					else
						cnt_q <= cnt_q - `LAT_W'd1;
				end
				default: state_q <= ACC_IDLE;
			endcase
		end
	end

	assign neg_fb_o = '{valid: neg_valid_q, warp_id: neg_warp_q, scb_id: neg_scb_q,
		mask: neg_mask_q};

endmodule

// File: mem_issue.sv
`timescale 1ns/10ps
`include "gpu_mem_defs.svh"

module mem_issue import gpu_mem_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic instr_valid_i,
	input  mem_op_e op_i,
	input  mem_space_e space_i,
	input  logic [`NUM_LANES-1:0] pam_i,
	input  logic [`WARP_W-1:0] warp_id_i,
	input  logic [`SCB_W-1:0] scb_id_i,
	input  logic [`REG_W-1:0] reg_addr_i,
	input  logic [`OFF_W-1:0] offset_i,
	input  logic [`NUM_LANES*`LANE_W-1:0] rs_data_i,
	input  logic [`NUM_LANES*`LANE_W-1:0] rt_data_i,
	output instr_hdr_t hdr_o,
	output logic hdr_valid_o,
	output lane_req_t [`NUM_LANES-1:0] lane_req_o,
	output instr_hdr_t lane_hdr_o,
	output logic lane_hdr_valid_o
);

	logic [`NUM_LANES*`LANE_W-1:0] rs_q;
	logic [`NUM_LANES*`LANE_W-1:0] rt_q;

	always_ff @(posedge clk)
	begin
		if (instr_valid_i)
		begin
			hdr_o <= '{op: op_i, space: space_i, warp_id: warp_id_i, scb_id: scb_id_i,
				reg_addr: reg_addr_i, offset: offset_i, pam: pam_i};
			rs_q <= rs_data_i;
			rt_q <= rt_data_i;
		end
		if (hdr_valid_o)
			lane_hdr_o <= hdr_o;	// Travels beside the lane registers.
	end

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			hdr_valid_o <= 1'b0;
			lane_hdr_valid_o <= 1'b0;
		end
		else
		begin
			hdr_valid_o <= instr_valid_i;
			lane_hdr_valid_o <= hdr_valid_o;
		end
	end

	always_comb
	begin
		for (int k = 0; k < `NUM_LANES; k++)
		begin
			lane_req_o[k].active = hdr_valid_o && hdr_o.pam[k] && (hdr_o.op != OP_NONE);
			lane_req_o[k].rs = rs_q[k*`LANE_W +: `LANE_W];
			lane_req_o[k].rt = rt_q[k*`LANE_W +: `LANE_W];
		end
	end

endmodule

// File: mem_lane_agu.sv
`timescale 1ns/10ps
`include "gpu_mem_defs.svh"

module mem_lane_agu import gpu_mem_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  lane_req_t req_i,
	input  instr_hdr_t hdr_i,
	output agu_out_t out_o
);

	logic [`LANE_W-1:0] eff_addr;
	logic [`LANE_W-1:0] limit;
	logic in_range;
	logic active_q;
	logic [`WADDR_W-1:0] addr_q;
	logic [`LANE_W-1:0] wdata_q;

	assign eff_addr = req_i.rs + {{(`LANE_W-`OFF_W){hdr_i.offset[`OFF_W-1]}}, hdr_i.offset};
	assign limit = (hdr_i.space == SPACE_SHARED) ? `LANE_W'(`SM_WORDS) : `LANE_W'(`GM_WORDS);
	assign in_range = (eff_addr < limit);	// Negative sums wrap high and fail here.

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
			active_q <= 1'b0;
		else
			active_q <= req_i.active && in_range;
	end

	always_ff @(posedge clk)
	begin
		addr_q <= eff_addr[`WADDR_W-1:0];
		wdata_q <= req_i.rt;
	end

	assign out_o = '{active: active_q, addr: addr_q, wdata: wdata_q};

endmodule

// File: mem_unit.sv
`timescale 1ns/10ps
`include "gpu_mem_defs.svh"

module mem_unit import gpu_mem_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic instr_valid_i,
	input  mem_op_e op_i,
	input  mem_space_e space_i,
	input  logic [`NUM_LANES-1:0] pam_i,
	input  logic [`WARP_W-1:0] warp_id_i,
	input  logic [`SCB_W-1:0] scb_id_i,
	input  logic [`REG_W-1:0] reg_addr_i,
	input  logic [`OFF_W-1:0] offset_i,
	input  logic [`NUM_LANES*`LANE_W-1:0] rs_data_i,
	input  logic [`NUM_LANES*`LANE_W-1:0] rt_data_i,
	input  logic fio_lat_we_i,
	input  logic [`LAT_W-1:0] fio_lat_i,
	output logic [`LAT_W-1:0] fio_lat_o,
	input  logic fio_mem_we_i,
	input  mem_space_e fio_space_i,
	input  logic [`WADDR_W-1:0] fio_addr_i,
	input  logic [`LANE_W-1:0] fio_wdata_i,
	output logic [`LANE_W-1:0] fio_rdata_o,
	output logic cdb_valid_o,
	output logic [`REG_W-1:0] cdb_reg_addr_o,
	output logic [`NUM_LANES-1:0] cdb_mask_o,
	output logic [`NUM_LANES*`LANE_W-1:0] cdb_data_o,
	output logic [`WARP_W-1:0] cdb_warp_id_o,
	output fb_t pos_fb_o,
	output fb_t neg_fb_o
);

	instr_hdr_t hdr;
	lane_req_t [`NUM_LANES-1:0] lane_req;
	instr_hdr_t lane_hdr;
	logic lane_hdr_valid;
	agu_out_t [`NUM_LANES-1:0] agu_out;
	wb_pkt_t wb_pkt;
	logic wb_valid;

	mem_issue u_issue
	(
		.clk(clk), .rst(rst), .instr_valid_i(instr_valid_i), .op_i(op_i), .space_i(space_i),
		.pam_i(pam_i), .warp_id_i(warp_id_i), .scb_id_i(scb_id_i), .reg_addr_i(reg_addr_i),
		.offset_i(offset_i), .rs_data_i(rs_data_i), .rt_data_i(rt_data_i),
		.hdr_o(hdr), .hdr_valid_o(), .lane_req_o(lane_req),	// Lane active bits carry the valid.
		.lane_hdr_o(lane_hdr), .lane_hdr_valid_o(lane_hdr_valid)
	);

	//////////////////////////////////////////////////
	// Per-lane address generation
	//////////////////////////////////////////////////
	for (genvar k = 0; k < `NUM_LANES; k++)
	begin : lane_gen
		mem_lane_agu u_agu
		(
			.clk(clk), .rst(rst), .req_i(lane_req[k]), .hdr_i(hdr), .out_o(agu_out[k])
		);
	end

	mem_access u_access
	(
		.clk(clk), .rst(rst), .hdr_i(lane_hdr), .hdr_valid_i(lane_hdr_valid),
		.lanes_i(agu_out),
		.fio_lat_we_i(fio_lat_we_i), .fio_lat_i(fio_lat_i), .fio_lat_o(fio_lat_o),
		.fio_mem_we_i(fio_mem_we_i), .fio_space_i(fio_space_i), .fio_addr_i(fio_addr_i),
		.fio_wdata_i(fio_wdata_i), .fio_rdata_o(fio_rdata_o),
		.wb_o(wb_pkt), .wb_valid_o(wb_valid), .neg_fb_o(neg_fb_o)
	);

	mem_writeback u_writeback
	(
		.clk(clk), .rst(rst), .wb_i(wb_pkt), .wb_valid_i(wb_valid),
		.cdb_valid_o(cdb_valid_o), .cdb_reg_addr_o(cdb_reg_addr_o), .cdb_mask_o(cdb_mask_o),
		.cdb_data_o(cdb_data_o), .cdb_warp_id_o(cdb_warp_id_o), .pos_fb_o(pos_fb_o)
	);

endmodule

// File: mem_unit_assert.sv
`timescale 1ns/10ps
`include "gpu_mem_defs.svh"

module mem_unit_assert import gpu_mem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic cdb_valid_o,
	input fb_t pos_fb_o,
	input fb_t neg_fb_o,
	input logic fio_lat_we_i,
	input logic [`LAT_W-1:0] fio_lat_o
);

	// Every bus write is also acknowledged to the scoreboard.
	load_acked: assert property (@(posedge clk) disable iff (!rst)
		cdb_valid_o |-> pos_fb_o.valid)
		else $error("bus write without positive feedback");

	quiet_in_reset: assert property (@(posedge clk)
		!rst |-> !cdb_valid_o && !pos_fb_o.valid && !neg_fb_o.valid)
		else $error("output strobe active during reset");

	lat_by_write: assert property (@(posedge clk) disable iff (!rst)
		$changed(fio_lat_o) |-> $past(fio_lat_we_i))
		else $error("latency changed without a debug write");

endmodule

bind mem_unit mem_unit_assert u_assert (.*);

// File: mem_writeback.sv
`timescale 1ns/10ps
`include "gpu_mem_defs.svh"

module mem_writeback import gpu_mem_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  wb_pkt_t wb_i,
	input  logic wb_valid_i,
	output logic cdb_valid_o,
	output logic [`REG_W-1:0] cdb_reg_addr_o,
	output logic [`NUM_LANES-1:0] cdb_mask_o,
	output logic [`NUM_LANES*`LANE_W-1:0] cdb_data_o,
	output logic [`WARP_W-1:0] cdb_warp_id_o,
	output fb_t pos_fb_o
);

	logic pos_valid_q;
	logic [`WARP_W-1:0] warp_q;
	logic [`SCB_W-1:0] scb_q;
	logic [`NUM_LANES-1:0] mask_q;

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			cdb_valid_o <= 1'b0;
			pos_valid_q <= 1'b0;
		end
		else
		begin
			cdb_valid_o <= wb_valid_i && (wb_i.op == OP_LOAD);	// Stores never touch the bus.
			pos_valid_q <= wb_valid_i && (wb_i.op != OP_NONE);
		end
	end

	always_ff @(posedge clk)
	begin
		if (wb_valid_i)
		begin
			cdb_reg_addr_o <= wb_i.reg_addr;
			cdb_data_o <= wb_i.rdata;
			warp_q <= wb_i.warp_id;
			scb_q <= wb_i.scb_id;
			mask_q <= wb_i.mask;
		end
	end

	//////////////////////////////////////////////////
	// Bus and scoreboard views of one result
	//////////////////////////////////////////////////
	assign cdb_mask_o = mask_q;
	assign cdb_warp_id_o = warp_q;
	assign pos_fb_o = '{valid: pos_valid_q, warp_id: warp_q, scb_id: scb_q, mask: mask_q};

endmodule

// File: tb_mem_unit.sv
`timescale 1ns/10ps
`include "gpu_mem_defs.svh"

module tb_mem_unit import gpu_mem_pkg::*;;

	localparam int N_OPS = 800;	// Instructions plus debug port operations.
	localparam int LIMIT = N_OPS * (4 + 31) + 200;

	typedef struct packed
	{
		int cyc;
		logic is_load;
		logic [`WARP_W-1:0] warp;
		logic [`SCB_W-1:0] scb;
		logic [`REG_W-1:0] reg_addr;
		logic [`NUM_LANES-1:0] mask;
		logic [`NUM_LANES*`LANE_W-1:0] data;
	} exp_t;

	logic clk, rst, instr_valid_i, fio_lat_we_i, fio_mem_we_i;
	mem_op_e op_i;
	mem_space_e space_i, fio_space_i;
	logic [`NUM_LANES-1:0] pam_i, cdb_mask_o;
	logic [`WARP_W-1:0] warp_id_i, cdb_warp_id_o;
	logic [`SCB_W-1:0] scb_id_i;
	logic [`REG_W-1:0] reg_addr_i, cdb_reg_addr_o;
	logic [`OFF_W-1:0] offset_i;
	logic [`NUM_LANES*`LANE_W-1:0] rs_data_i, rt_data_i, cdb_data_o;
	logic [`LAT_W-1:0] fio_lat_i, fio_lat_o;
	logic [`WADDR_W-1:0] fio_addr_i;
	logic [`LANE_W-1:0] fio_wdata_i, fio_rdata_o;
	logic cdb_valid_o;
	fb_t pos_fb_o, neg_fb_o;

	logic [`LANE_W-1:0] gm_model [`GM_WORDS];
	logic [`LANE_W-1:0] sm_model [`SM_WORDS];
	exp_t pos_q[$];
	exp_t neg_q[$];
	int cyc = 0;
	int busy_end = -1;	// Last issue edge that collides with a pending global access.
	int cur_lat = `LAT_RESET;
	logic [30:0] rng = 31'd12802;

	mem_unit DUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////
	function automatic int unsigned lcg(input int unsigned range);
		rng = 31'(rng * 31'd1103515245 + 31'd12345);
		return int'(rng[30:8]) % range;
	endfunction

	task automatic report_error(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped on first error");
	endtask

	// Applies the lane rules to the model arrays and returns mask and load data.
	function automatic void ref_model(input mem_op_e op, input mem_space_e sp,
		input logic [7:0] pam, input logic [15:0] off, input logic [255:0] rs,
		input logic [255:0] rt, output logic [7:0] mask, output logic [255:0] rdata);
		logic [31:0] addr;
		int lim;
		lim = (sp == SPACE_SHARED) ? `SM_WORDS : `GM_WORDS;
		for (int k = 0; k < `NUM_LANES; k++)
		begin
			addr = rs[k*32 +: 32] + {{16{off[15]}}, off};
			mask[k] = pam[k] && (addr < 32'(lim));
			rdata[k*32 +: 32] = '0;
			if (mask[k] && op == OP_STORE && sp == SPACE_SHARED)
				sm_model[addr[7:0]] = rt[k*32 +: 32];
			else if (mask[k] && op == OP_STORE)
				gm_model[addr[7:0]] = rt[k*32 +: 32];
			else if (mask[k])
				rdata[k*32 +: 32] = (sp == SPACE_SHARED) ? sm_model[addr[7:0]] : gm_model[addr[7:0]];
		end
	endfunction

	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge clk);
			instr_valid_i <= 1'b0;
			fio_lat_we_i <= 1'b0;
			fio_mem_we_i <= 1'b0;
		end
	endtask

	task automatic issue_instr(input mem_op_e op, input mem_space_e sp, input logic [7:0] pam,
		input logic [15:0] off, input logic [255:0] rs, input logic [255:0] rt);
		exp_t e;
		int e0;
		@(posedge clk);
		e0 = cyc + 1;	// Count after the edge that puts the strobe on the input.
		e.warp = 3'(lcg(8));
		e.scb = 2'(lcg(4));
		e.reg_addr = 5'(lcg(32));
		e.is_load = (op == OP_LOAD);
		instr_valid_i <= 1'b1;
		op_i <= op;
		space_i <= sp;
		pam_i <= pam;
		offset_i <= off;
		rs_data_i <= rs;
		rt_data_i <= rt;
		warp_id_i <= e.warp;
		scb_id_i <= e.scb;
		reg_addr_i <= e.reg_addr;
		if (e0 <= busy_end)
		begin
			e.cyc = e0 + 3;
			e.mask = pam;
			e.data = '0;
			neg_q.push_back(e);
		end
		else
		begin
			ref_model(op, sp, pam, off, rs, rt, e.mask, e.data);
			e.cyc = e0 + 4 + ((sp == SPACE_GLOBAL) ? cur_lat : 0);
			if (sp == SPACE_GLOBAL && cur_lat > 0)
				busy_end = e0 + cur_lat;
			pos_q.push_back(e);
		end
	endtask

	task automatic drain();
		while (pos_q.size() != 0 || neg_q.size() != 0)
			idle(1);
		idle(2);
	endtask

	task automatic set_lat(input int v);
		drain();
		@(posedge clk);
		fio_lat_we_i <= 1'b1;
		fio_lat_i <= 5'(v);
		idle(1);
		cur_lat = v;
		@(negedge clk);
		assert (fio_lat_o == 5'(v)) else report_error("latency register readback mismatch");
	endtask

	task automatic dbg_check(input mem_space_e sp, input int a);
		@(posedge clk);
		fio_space_i <= sp;
		fio_addr_i <= 8'(a);
		@(negedge clk);
		assert (fio_rdata_o == ((sp == SPACE_SHARED) ? sm_model[a] : gm_model[a]))
			else report_error("debug port read mismatch");
	endtask

	function automatic logic [255:0] lanes_from(input int base, input int stride);
		logic [255:0] v;
		for (int k = 0; k < `NUM_LANES; k++)
			v[k*32 +: 32] = 32'(base + k * stride);
		return v;
	endfunction

	function automatic logic [255:0] rand_words(input int range);
		logic [255:0] v;
		for (int k = 0; k < `NUM_LANES; k++)
			v[k*32 +: 32] = 32'(lcg(range));
		return v;
	endfunction

	//////////////////////////////////////////////////
	// Cycle count, timeout and comparison
	//////////////////////////////////////////////////
	always @(posedge clk)
	begin
		cyc <= cyc + 1;
		if (cyc >= LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", LIMIT);
			$display("CHECKS FAILED");
			$fatal(1, "timeout");
		end
	end

	always @(negedge clk)
	begin
		if (rst)
		begin
			if (pos_q.size() != 0 && pos_q[0].cyc == cyc)
			begin
				assert (pos_fb_o.valid && pos_fb_o.warp_id == pos_q[0].warp
					&& pos_fb_o.scb_id == pos_q[0].scb && pos_fb_o.mask == pos_q[0].mask)
					else report_error("positive feedback missing or wrong");
				assert (cdb_valid_o == pos_q[0].is_load) else report_error("bus strobe wrong");
				if (pos_q[0].is_load)
					assert (cdb_reg_addr_o == pos_q[0].reg_addr && cdb_mask_o == pos_q[0].mask
						&& cdb_data_o == pos_q[0].data && cdb_warp_id_o == pos_q[0].warp)
						else report_error("bus payload mismatch");
				void'(pos_q.pop_front());
			end
			else
				assert (!pos_fb_o.valid && !cdb_valid_o) else report_error("unexpected result");
			if (neg_q.size() != 0 && neg_q[0].cyc == cyc)
			begin
				assert (neg_fb_o.valid && neg_fb_o.warp_id == neg_q[0].warp
					&& neg_fb_o.scb_id == neg_q[0].scb && neg_fb_o.mask == neg_q[0].mask)
					else report_error("negative feedback missing or wrong");
				void'(neg_q.pop_front());
			end
			else
				assert (!neg_fb_o.valid) else report_error("unexpected negative feedback");
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	initial
	begin
		{instr_valid_i, fio_lat_we_i, fio_mem_we_i, pam_i, warp_id_i, scb_id_i} = '0;
		{reg_addr_i, offset_i, rs_data_i, rt_data_i, fio_lat_i, fio_addr_i, fio_wdata_i} = '0;
		op_i = OP_NONE;
		space_i = SPACE_GLOBAL;
		fio_space_i = SPACE_GLOBAL;
		rst = 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		assert (fio_lat_o == 5'(`LAT_RESET)) else report_error("latency reset value wrong");
		for (int a = 0; a < 512; a++)
		begin
			@(posedge clk);
			fio_mem_we_i <= 1'b1;
			fio_space_i <= (a >= 256) ? SPACE_SHARED : SPACE_GLOBAL;
			fio_addr_i <= 8'(a);
			fio_wdata_i <= 32'hC3A50000 ^ (32'(a) * 32'h01030107);
			if (a >= 256)
				sm_model[a - 256] = 32'hC3A50000 ^ (32'(a) * 32'h01030107);
			else
				gm_model[a] = 32'hC3A50000 ^ (32'(a) * 32'h01030107);
		end
		idle(1);
		dbg_check(SPACE_GLOBAL, 0);
		dbg_check(SPACE_SHARED, 255);
		set_lat(9);
		issue_instr(OP_STORE, SPACE_SHARED, 8'hFF, 16'd0, lanes_from(16, 1), rand_words(1 << 30));
		issue_instr(OP_LOAD, SPACE_SHARED, 8'h5A, 16'd0, lanes_from(16, 1), '0);
		set_lat(0);
		issue_instr(OP_LOAD, SPACE_GLOBAL, 8'hF3, 16'd2, lanes_from(40, 3), '0);
		set_lat(3);
		issue_instr(OP_LOAD, SPACE_GLOBAL, 8'hFF, 16'd0, lanes_from(40, 3), '0);
		set_lat(7);
		issue_instr(OP_LOAD, SPACE_GLOBAL, 8'h3C, 16'hFFFF, lanes_from(41, 3), '0);
		drain();
		issue_instr(OP_STORE, SPACE_GLOBAL, 8'hFF, 16'd3, lanes_from(248, 1), rand_words(1000));
		issue_instr(OP_STORE, SPACE_SHARED, 8'hFF, 16'hFFFC, lanes_from(0, 1), rand_words(1000));
		drain();
		// Out-of-range lanes wrap onto these words if they are not masked.
		for (int a = 0; a < 3; a++)
			dbg_check(SPACE_GLOBAL, a);
		for (int a = 252; a < 256; a++)
			dbg_check(SPACE_SHARED, a);
		issue_instr(OP_LOAD, SPACE_GLOBAL, 8'hFF, 16'd0, lanes_from(248, 1), '0);
		issue_instr(OP_LOAD, SPACE_SHARED, 8'hFF, 16'd0, lanes_from(0, 1), '0);
		set_lat(5);
		issue_instr(OP_LOAD, SPACE_GLOBAL, 8'hFF, 16'd0, lanes_from(100, 1), '0);
		issue_instr(OP_STORE, SPACE_SHARED, 8'h0F, 16'd0, lanes_from(10, 1), rand_words(77));
		idle(1);
		issue_instr(OP_LOAD, SPACE_SHARED, 8'hA5, 16'd0, lanes_from(10, 1), '0);
		drain();
		issue_instr(OP_LOAD, SPACE_SHARED, 8'hFF, 16'd0, lanes_from(10, 1), '0);
		for (int n = 0; n < 200; n++)
		begin
			if (n % 25 == 0)
				set_lat(lcg(8));
			issue_instr((lcg(2) == 0) ? OP_LOAD : OP_STORE,
				(lcg(2) == 0) ? SPACE_GLOBAL : SPACE_SHARED, 8'(lcg(256)),
				16'(int'(lcg(17)) - 8), rand_words(264), rand_words(1 << 30));
			idle(lcg(4));
		end
		drain();
		dbg_check(SPACE_SHARED, 12);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule
